// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= issue_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dispatch_unit.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module dispatch_unit (
    input  logic              clk,
    input  logic              rst,
    input  iq_pkg::uop_t      head_uop,
    input  logic              not_empty,
    input  logic              rs_release,
    input  logic              rob_commit,
    output logic              pop,
    output iq_pkg::dispatch_t disp,
    output logic              disp_valid
);

    logic [$clog2(`RS_SLOTS):0]    rs_cnt;  // busy reservation station slots
    logic [$clog2(`ROB_SLOTS):0]   rob_cnt; // busy reorder buffer slots
    logic [$clog2(`ROB_SLOTS)-1:0] rob_tag;
    logic                          rs_room;
    logic                          rob_room;

    assign rs_room  = (rs_cnt < `RS_SLOTS);
    assign rob_room = (rob_cnt < `ROB_SLOTS);
    assign pop      = not_empty && rs_room && rob_room;

    // ********************
    // occupancy
    // ********************
    always_ff @(posedge clk) begin
        if (!rst) begin
            rs_cnt  <= '0;
            rob_cnt <= '0;
        end else begin
            case ({pop, rs_release})
                2'b10:   rs_cnt <= rs_cnt + 1'b1;
                2'b01:   rs_cnt <= (rs_cnt != '0) ? rs_cnt - 1'b1 : rs_cnt;
                default: rs_cnt <= rs_cnt; // same cycle in and out
            endcase
            case ({pop, rob_commit})
                2'b10:   rob_cnt <= rob_cnt + 1'b1;
                2'b01:   rob_cnt <= (rob_cnt != '0) ? rob_cnt - 1'b1 : rob_cnt;
                default: rob_cnt <= rob_cnt;
            endcase
        end
    end

    // ********************
    // tag and output
    // ********************
    always_ff @(posedge clk) begin
        if (!rst) begin
            rob_tag    <= '0;
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= pop;
            if (pop) begin
                if (rob_tag == `ROB_SLOTS - 1) begin
                    rob_tag <= '0;
                end else begin
                    rob_tag <= rob_tag + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            disp.uop     <= head_uop;
            disp.rob_tag <= rob_tag; // tag before the advance
        end
    end

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic         clk,
    input  logic         rst,
    input  logic [31:0]  instr,
    input  logic         instr_valid,
    output iq_pkg::uop_t uop,
    output logic         uop_valid
);

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic [31:0]  imm_i;
    logic [31:0]  imm_s;
    logic [31:0]  imm_b;
    logic [31:0]  imm_u;
    iq_pkg::uop_t dec;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ********************
    // immediates by format
    // ********************
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // ********************
    // class decode
    // ********************
    always_comb begin
        dec = '0;
        dec.op = iq_pkg::OP_NOP; // unused fields stay zero
        case (opcode)
            7'b0110011: begin // r-type alu
                dec.rs1 = instr[19:15];
                dec.rs2 = instr[24:20];
                dec.rd  = instr[11:7];
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    dec.op = iq_pkg::OP_ADD;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    dec.op = iq_pkg::OP_SUB;
                end else if (funct3 == 3'b111 && funct7 == 7'b0000000) begin
                    dec.op = iq_pkg::OP_AND;
                end else if (funct3 == 3'b110 && funct7 == 7'b0000000) begin
                    dec.op = iq_pkg::OP_OR;
                end
            end
            7'b0010011: begin
                if (funct3 == 3'b000) begin
                    dec.op      = iq_pkg::OP_ADDI;
                    dec.rs1     = instr[19:15];
                    dec.rd      = instr[11:7];
                    dec.imm     = imm_i;
                    dec.has_imm = 1'b1;
                end
            end
            7'b0110111: begin
                dec.op      = iq_pkg::OP_LUI;
                dec.rd      = instr[11:7];
                dec.imm     = imm_u;
                dec.has_imm = 1'b1;
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin
                    dec.op      = iq_pkg::OP_LW;
                    dec.rs1     = instr[19:15];
                    dec.rd      = instr[11:7];
                    dec.imm     = imm_i;
                    dec.has_imm = 1'b1;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b010) begin
                    dec.op      = iq_pkg::OP_SW;
                    dec.rs1     = instr[19:15];
                    dec.rs2     = instr[24:20];
                    dec.imm     = imm_s;
                    dec.has_imm = 1'b1;
                end
            end
            7'b1100011: begin
                if (funct3 == 3'b000) begin
                    dec.op      = iq_pkg::OP_BEQ;
                    dec.rs1     = instr[19:15];
                    dec.rs2     = instr[24:20];
                    dec.imm     = imm_b;
                    dec.has_imm = 1'b1;
                end
            end
            default: dec.op = iq_pkg::OP_NOP;
        endcase
        // anything that fell through keeps all fields zero
        if (dec.op == iq_pkg::OP_NOP) begin
            dec = '0;
            dec.op = iq_pkg::OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            uop_valid <= 1'b0;
        end else begin
            uop_valid <= instr_valid && (dec.op != iq_pkg::OP_NOP); // nop never queued
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            uop <= dec;
        end
    end

endmodule

// ==== inst_queue.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module inst_queue (
    input  logic         clk,
    input  logic         rst,
    input  iq_pkg::uop_t uop,
    input  logic         uop_valid,
    input  logic         pop,
    output iq_pkg::uop_t head_uop,
    output logic         not_empty,
    output logic         iq_full
);

    iq_pkg::uop_t         mem [`IQ_DEPTH];
    logic [`IQ_PTR_W-1:0] head;
    logic [`IQ_PTR_W-1:0] tail;
    logic [`IQ_PTR_W:0]   count;     // 0 .. IQ_DEPTH
    logic [`IQ_PTR_W:0]   occupancy; // queue plus decoder register

    // ********************
    // storage
    // ********************
    always_ff @(posedge clk) begin
        if (uop_valid) begin
            mem[tail] <= uop;
        end
    end

    assign head_uop = mem[head];

    // ********************
    // pointers and count
    // ********************
    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (uop_valid) begin
                tail <= tail + 1'b1; // wraps at IQ_DEPTH
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({uop_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // push and pop cancel
            endcase
        end
    end

    assign not_empty = (count != '0);

    // the micro-op still in the decoder register already owns a slot,
    // so fetch is held off one entry early and a push always finds room
    assign occupancy = count + {{`IQ_PTR_W{1'b0}}, uop_valid};
    assign iq_full   = (occupancy >= `IQ_DEPTH);

endmodule

// ==== iq_consts.svh ====
`ifndef IQ_CONSTS_SVH
`define IQ_CONSTS_SVH

// ********************
// instruction queue
// ********************
`define IQ_DEPTH   16   // queue entries
`define IQ_PTR_W   4    // head and tail pointer width

// ********************
// back end resources
// ********************
`define RS_SLOTS   4    // reservation station entries
`define ROB_SLOTS  8    // reorder buffer entries, 3 bit tags

// decoder output for anything outside the supported classes
`define OP_NOP     31

`endif

// ==== iq_pkg.sv ====
`include "iq_consts.svh"

package iq_pkg;

    // internal op codes, nop sits at the top of the 5 bit range
    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_AND  = 5'd2,
        OP_OR   = 5'd3,
        OP_ADDI = 5'd4,
        OP_LUI  = 5'd5,
        OP_LW   = 5'd6,
        OP_SW   = 5'd7,
        OP_BEQ  = 5'd8,
        OP_NOP  = 5'(`OP_NOP)
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;     // sign extended, or upper immediate for lui
        logic        has_imm;
    } uop_t;

    typedef struct packed {
        uop_t                          uop;
        logic [$clog2(`ROB_SLOTS)-1:0] rob_tag;
    } dispatch_t;

endpackage

// ==== issue_cases.txt ====
# I instr_hex op rs1 rs2 rd imm_hex has_imm   (op, rs and rd in decimal)
# R releases commits
I 002081B3 0 1 2 3 00000000 0
I 407302B3 1 6 7 5 00000000 0
I 00A4F433 2 9 10 8 00000000 0
I 00D665B3 3 12 13 11 00000000 0
I FFB10093 4 2 0 1 FFFFFFFB 1
I 00000073 31 0 0 0 00000000 0
I 06400213 4 0 0 4 00000064 1
I 123453B7 5 0 0 7 12345000 1
I FFFFF137 5 0 0 2 FFFFF000 1
I 0020C1B3 31 0 0 0 00000000 0
I 0082A303 6 5 0 6 00000008 1
I FFC52483 6 10 0 9 FFFFFFFC 1
I 00322623 7 4 3 0 0000000C 1
I FE84A823 7 9 8 0 FFFFFFF0 1
I 00208863 8 1 2 0 00000010 1
I FE418CE3 8 3 4 0 FFFFFFF8 1
I FFFFFFFF 31 0 0 0 00000000 0
R 4 0
R 0 8
R 4 4
I 002081B3 0 1 2 3 00000000 0
I 407302B3 1 6 7 5 00000000 0
I 00A4F433 2 9 10 8 00000000 0
I 00D665B3 3 12 13 11 00000000 0
I FFB10093 4 2 0 1 FFFFFFFB 1
I 06400213 4 0 0 4 00000064 1
I 123453B7 5 0 0 7 12345000 1
I FFFFF137 5 0 0 2 FFFFF000 1
I 0082A303 6 5 0 6 00000008 1
I FFC52483 6 10 0 9 FFFFFFFC 1
I 00322623 7 4 3 0 0000000C 1
I FE84A823 7 9 8 0 FFFFFFF0 1
I 00208863 8 1 2 0 00000010 1
I FE418CE3 8 3 4 0 FFFFFFF8 1
I 002081B3 0 1 2 3 00000000 0
I 407302B3 1 6 7 5 00000000 0
I 00A4F433 2 9 10 8 00000000 0
I 00D665B3 3 12 13 11 00000000 0
R 8 8

// ==== issue_checker.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module issue_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 uop_valid,
    input logic                 disp_valid,
    input logic [`IQ_PTR_W:0]   count
);

    // ********************
    // queue rules
    // ********************
    // a pop from an empty queue wraps the count past IQ_DEPTH
    count_in_range: assert property (@(posedge clk) disable iff (!rst) count <= `IQ_DEPTH)
        else $error("pop without a queued entry");

    push_has_room: assert property (@(posedge clk) disable iff (!rst)
        uop_valid |-> (count < `IQ_DEPTH))
        else $error("push into a full queue");

    // sync reset clears disp_valid at the first edge
    quiet_in_reset: assert property (@(posedge clk) !rst |=> !disp_valid)
        else $error("disp_valid high during reset");

endmodule

bind issue_top issue_checker checker_inst (
    .clk        (clk),
    .rst        (rst),
    .uop_valid  (uop_valid),
    .disp_valid (disp_valid),
    .count      (queue_inst.count)
);

// ==== issue_tb.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module issue_tb;

    localparam int MAX_CASES = 64;

    logic              clk;
    logic              rst;
    logic [31:0]       instr;
    logic              instr_valid;
    logic              rs_release;
    logic              rob_commit;
    logic              iq_full;
    iq_pkg::dispatch_t disp;
    logic              disp_valid;

    // case table, filled from the case file
    logic [7:0]   kind    [MAX_CASES];
    logic [31:0]  word    [MAX_CASES];
    iq_pkg::uop_t exp_uop [MAX_CASES];
    int           n_rel   [MAX_CASES];
    int           n_com   [MAX_CASES];
    int           n_cases;
    logic         loaded;

    iq_pkg::uop_t sb_uop  [$]; // scoreboard, in accept order
    string        sb_name [$];

    integer     seed;
    logic       cur_supported;
    logic       rel_prev;
    logic       com_prev;
    int         accepted;
    int         dispatched;
    int         rs_model;
    int         rob_model;
    logic [2:0] tag_model;

    issue_top issue_top_inst (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs_release  (rs_release),
        .rob_commit  (rob_commit),
        .iq_full     (iq_full),
        .disp        (disp),
        .disp_valid  (disp_valid)
    );

    always #2 clk = ~clk;

    // ********************
    // compare tasks
    // ********************
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_uop(input string name, input iq_pkg::uop_t exp, input iq_pkg::uop_t act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s rob_tag: expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_level(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s: expected %b actual %b", name, exp, act));
        end
    endtask

    // ********************
    // case file
    // ********************
    task automatic load_cases();
        integer fd;
        string  line;
        int     op_num;
        int     rs1;
        int     rs2;
        int     rd;
        int     has_imm;
        logic [31:0] imm;
        fd = $fopen("issue_cases.txt", "r");
        if (fd == 0) begin
            stop_run("could not open issue_cases.txt");
        end
        n_cases = 0;
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "I") begin
                void'($sscanf(line, "I %h %d %d %d %d %h %d",
                              word[n_cases], op_num, rs1, rs2, rd, imm, has_imm));
                kind[n_cases]            = "I";
                exp_uop[n_cases].op      = iq_pkg::op_e'(op_num);
                exp_uop[n_cases].rs1     = rs1[4:0];
                exp_uop[n_cases].rs2     = rs2[4:0];
                exp_uop[n_cases].rd      = rd[4:0];
                exp_uop[n_cases].imm     = imm;
                exp_uop[n_cases].has_imm = has_imm[0];
            end else begin
                void'($sscanf(line, "R %d %d", n_rel[n_cases], n_com[n_cases]));
                kind[n_cases] = "R";
            end
            n_cases++;
        end
        $fclose(fd);
    endtask

    // ********************
    // stimulus helpers
    // ********************
    task automatic next_cycle();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        rs_release  = 1'b0;
        rob_commit  = 1'b0;
    endtask

    // pulses both resources now and then so a full queue can drain
    task automatic wait_not_full();
        int stalled;
        stalled = 0;
        while (iq_full) begin
            stalled++;
            if (stalled % 8 == 0) begin
                rs_release = 1'b1;
                rob_commit = 1'b1;
            end
            next_cycle();
        end
    endtask

    task automatic send_word(input int idx);
        int gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) next_cycle();
        wait_not_full();
        instr         = word[idx];
        instr_valid   = 1'b1;
        cur_supported = (exp_uop[idx].op != iq_pkg::op_e'(`OP_NOP));
        if (cur_supported) begin
            sb_uop.push_back(exp_uop[idx]);
            sb_name.push_back($sformatf("case %0d", idx));
        end
        next_cycle();
    endtask

    task automatic send_pulses(input int rel, input int com);
        int k;
        for (k = 0; k < rel || k < com; k++) begin
            rs_release = (k < rel);
            rob_commit = (k < com);
            next_cycle();
        end
    endtask

    // ********************
    // monitor and models
    // ********************
    always @(posedge clk) begin
        rel_prev <= rs_release;
        com_prev <= rob_commit;
        if (instr_valid && cur_supported) begin
            accepted++;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            if (disp_valid) begin
                if (sb_uop.size() == 0) begin
                    stop_run("a micro-op was dispatched that was never expected");
                end
                if (rs_model >= `RS_SLOTS || rob_model >= `ROB_SLOTS) begin
                    stop_run("a micro-op was dispatched with no free slot");
                end
                check_uop(sb_name[0], sb_uop[0], disp.uop);
                check_tag(sb_name[0], tag_model, disp.rob_tag);
                void'(sb_uop.pop_front());
                void'(sb_name.pop_front());
                tag_model = tag_model + 3'd1; // wraps at 8
                dispatched++;
            end
            if (disp_valid && !rel_prev) rs_model++;
            else if (!disp_valid && rel_prev && rs_model > 0) rs_model--;
            if (disp_valid && !com_prev) rob_model++;
            else if (!disp_valid && com_prev && rob_model > 0) rob_model--;
            compare_level("iq_full", (accepted - dispatched) >= `IQ_DEPTH, iq_full);
        end
    end

    initial begin
        wait (loaded);
        #((n_cases + 50) * 20 * 4);
        $display("timeout: the dispatch stream did not finish in time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    // ********************
    // main sequence
    // ********************
    initial begin
        int i;
        int drain;
        clk = 1'b0;
        rst = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        rs_release = 1'b0;
        rob_commit = 1'b0;
        cur_supported = 1'b0;
        accepted = 0;
        dispatched = 0;
        rs_model = 0;
        rob_model = 0;
        tag_model = '0;
        seed = 46145;
        drain = 0;
        loaded = 1'b0;
        load_cases();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        for (i = 0; i < n_cases; i++) begin
            if (kind[i] == "I") send_word(i);
            else send_pulses(n_rel[i], n_com[i]);
        end
        while (sb_uop.size() != 0 && drain < 2 * `IQ_DEPTH) begin // drain the queue
            send_pulses(1, 1);
            drain++;
        end
        repeat (10) next_cycle();
        if (sb_uop.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("scoreboard not empty at the end of the run");
            $display("Done: errors found");
            $fatal(1, "run stopped");
        end
    end

endmodule

// ==== issue_top.sv ====
`timescale 1ns/1ps

module issue_top (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       instr,
    input  logic              instr_valid,
    input  logic              rs_release,
    input  logic              rob_commit,
    output logic              iq_full,
    output iq_pkg::dispatch_t disp,
    output logic              disp_valid
);

    iq_pkg::uop_t uop;
    logic         uop_valid;
    iq_pkg::uop_t head_uop;
    logic         not_empty;
    logic         pop;

    inst_decoder decoder_inst (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .uop         (uop),
        .uop_valid   (uop_valid)
    );

    inst_queue queue_inst (
        .clk       (clk),
        .rst       (rst),
        .uop       (uop),
        .uop_valid (uop_valid),
        .pop       (pop),
        .head_uop  (head_uop),
        .not_empty (not_empty),
        .iq_full   (iq_full)
    );

    dispatch_unit dispatch_inst (
        .clk        (clk),
        .rst        (rst),
        .head_uop   (head_uop),
        .not_empty  (not_empty),
        .rs_release (rs_release),
        .rob_commit (rob_commit),
        .pop        (pop),
        .disp       (disp),
        .disp_valid (disp_valid)
    );

endmodule

// ==== src.f ====
+incdir+.
iq_pkg.sv
inst_decoder.sv
inst_queue.sv
dispatch_unit.sv
issue_top.sv
issue_checker.sv
issue_tb.sv
